//--- reg_rename_defs.svh
/*
 * Register renamer sizing
 * Register counts, index widths and list depths
 */
`ifndef REG_RENAME_DEFS_SVH
`define REG_RENAME_DEFS_SVH

// Architectural register file
`define ARCH_REGS 32
`define ARCH_W 5

// Physical register file
`define PHYS_REGS 64
`define PHYS_W 6

// List capacities
// Free list holds every register not mapped at reset
`define FREE_DEPTH 32
// One record per outstanding renamed destination
`define INUSE_DEPTH 32

`endif

//--- reg_rename_pkg.sv
/*
 * Register renamer types
 * Register number typedefs, in-use record layout and init states
 */
`include "reg_rename_defs.svh"

package reg_rename_pkg;

    // Architectural register number
    typedef logic [`ARCH_W-1:0] arch_addr_t;

    // Physical register number
    typedef logic [`PHYS_W-1:0] phys_addr_t;

    // In-use record, from the top
    //   [16:12] architectural destination
    //   [11:6]  newly given physical register
    //   [5:0]   previous physical register
    typedef logic [`ARCH_W+2*`PHYS_W-1:0] inuse_rec_t;

    // Post-reset table fill sequencer
    typedef enum logic {
        INIT_FILL,
        INIT_DONE
    } init_state_t;

endpackage

//--- free_list.sv
/*
 * Free list of physical registers
 * Circular FIFO, self-loaded with the upper physical registers after reset
 */
`include "reg_rename_defs.svh"

module free_list
    import reg_rename_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       free_pop,
    input  logic       free_push,
    input  phys_addr_t free_push_phys,
    output phys_addr_t free_head,
    output logic       free_avail,
    output logic       init_active,
    output arch_addr_t init_index
);
    localparam int PTR_W = $clog2(`FREE_DEPTH);
    localparam int CNT_W = $clog2(`FREE_DEPTH + 1);
    // Last fill index, one entry per unmapped physical register
    localparam int INIT_LAST = `PHYS_REGS - `ARCH_REGS - 1;

    init_state_t      init_state;
    arch_addr_t       init_cnt;

    phys_addr_t       fifo_mem [`FREE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic             push_en;
    logic             pop_en;
    phys_addr_t       push_data;

    //////////////////////////////
    // Init sequencer
    //////////////////////////////
    // Counts 0..31 once after reset, one fill step per cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            init_state <= INIT_FILL;
            init_cnt   <= '0;
        end else if (init_state == INIT_FILL) begin
            init_cnt <= init_cnt + 1'b1;
            if (init_cnt == arch_addr_t'(INIT_LAST)) begin
                init_state <= INIT_DONE;
            end
        end
    end

    assign init_active = (init_state == INIT_FILL);
    assign init_index  = init_cnt;

    //////////////////////////////
    // FIFO storage
    //////////////////////////////
    // Fill pushes 32+i, otherwise the register freed at retire
    assign push_en   = init_active | free_push;
    assign push_data = init_active ? phys_addr_t'(`ARCH_REGS) + phys_addr_t'(init_cnt)
                                   : free_push_phys;
    assign pop_en    = free_pop & free_avail;

    always_ff @(posedge clk) begin
        if (push_en) begin
            fifo_mem[wr_ptr] <= push_data;
        end
    end

    // Depth is a power of two so pointers wrap on their own
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            count <= count + CNT_W'(push_en) - CNT_W'(pop_en);
        end
    end

    // Oldest entry, shown before it is taken
    assign free_head  = fifo_mem[rd_ptr];
    assign free_avail = (count != '0);

endmodule

//--- spec_map_table.sv
/*
 * Speculative map table
 * Architectural to physical map with three reads and one prioritized write
 */
`include "reg_rename_defs.svh"

module spec_map_table
    import reg_rename_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       init_active,
    input  arch_addr_t init_index,
    input  logic       rename_valid,
    input  arch_addr_t rd,
    input  arch_addr_t rs1,
    input  arch_addr_t rs2,
    output logic       rename_ready,
    output phys_addr_t phys_rd,
    output phys_addr_t phys_rs1,
    output phys_addr_t phys_rs2,
    input  phys_addr_t free_head,
    input  logic       free_avail,
    output logic       free_pop,
    input  logic       inuse_full,
    output logic       rec_push,
    output inuse_rec_t rec_in,
    input  logic       restore_valid,
    input  arch_addr_t restore_arch,
    input  phys_addr_t restore_phys
);
    phys_addr_t map_q [`ARCH_REGS];

    logic       map_loaded;
    phys_addr_t prev_phys;
    logic       rename_fire;
    logic       rename_wr;

    logic       map_we;
    arch_addr_t map_waddr;
    phys_addr_t map_wdata;

    //////////////////////////////
    // Lookups
    //////////////////////////////
    // Register zero always reads physical zero
    assign phys_rs1  = (rs1 == '0) ? '0 : map_q[rs1];
    assign phys_rs2  = (rs2 == '0) ? '0 : map_q[rs2];
    // Mapping about to be replaced, kept in the record
    assign prev_phys = map_q[rd];

    // Fresh destination only for a real rd
    assign phys_rd = (rd == '0) ? '0 : free_head;

    //////////////////////////////
    // Rename handshake
    //////////////////////////////
    // Set by the last fill write, so ready can rise the cycle after
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            map_loaded <= 1'b0;
        end else if (init_active && init_index == arch_addr_t'(`ARCH_REGS - 1)) begin
            map_loaded <= 1'b1;
        end
    end

    // Stall while filling, out of registers, out of records, or
    // while a restore owns the write port
    assign rename_ready = map_loaded & free_avail & ~inuse_full & ~restore_valid;
    assign rename_fire  = rename_valid & rename_ready;
    // rd of zero is accepted but consumes nothing
    assign rename_wr    = rename_fire & (rd != '0);

    assign free_pop = rename_wr;
    assign rec_push = rename_wr;
    assign rec_in   = {rd, free_head, prev_phys};

    //////////////////////////////
    // Write port
    //////////////////////////////
    // Priority init, then restore, then rename
    always_comb begin
        map_we    = 1'b0;
        map_waddr = rd;
        map_wdata = free_head;
        if (init_active) begin
            // Identity mapping
            map_we    = 1'b1;
            map_waddr = init_index;
            map_wdata = phys_addr_t'(init_index);
        end else if (restore_valid) begin
            map_we    = 1'b1;
            map_waddr = restore_arch;
            map_wdata = restore_phys;
        end else if (rename_wr) begin
            map_we = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (map_we) begin
            map_q[map_waddr] <= map_wdata;
        end
    end

endmodule

//--- inuse_list.sv
/*
 * In-use list
 * Program-order FIFO of rename records with a valid/ready head
 */
`include "reg_rename_defs.svh"

module inuse_list
    import reg_rename_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       rec_push,
    input  inuse_rec_t rec_in,
    output logic       inuse_full,
    output logic       head_valid,
    output inuse_rec_t head_rec,
    input  logic       head_ready
);
    localparam int PTR_W = $clog2(`INUSE_DEPTH);
    localparam int CNT_W = $clog2(`INUSE_DEPTH + 1);

    inuse_rec_t       rec_mem [`INUSE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic             push_en;
    logic             pop_en;

    // Push is only offered while not full
    assign push_en = rec_push & ~inuse_full;
    // Head leaves on its handshake
    assign pop_en  = head_valid & head_ready;

    always_ff @(posedge clk) begin
        if (push_en) begin
            rec_mem[wr_ptr] <= rec_in;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push_en) - CNT_W'(pop_en);
        end
    end

    // Flags from the occupancy count
    assign inuse_full = (count == CNT_W'(`INUSE_DEPTH));
    assign head_valid = (count != '0);
    // Oldest outstanding rename
    assign head_rec   = rec_mem[rd_ptr];

endmodule

//--- retire_reclaim.sv
/*
 * Retire reclaim
 * Frees registers at retire and decides which discards restore the map
 */
`include "reg_rename_defs.svh"

module retire_reclaim
    import reg_rename_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       retire_valid,
    input  logic       retire_discard,
    input  logic       flush,
    output logic       retire_ready,
    input  logic       head_valid,
    input  inuse_rec_t head_rec,
    output logic       head_ready,
    output logic       free_push,
    output phys_addr_t free_push_phys,
    output logic       restore_valid,
    output arch_addr_t restore_arch,
    output phys_addr_t restore_phys
);
    logic [`ARCH_REGS-1:0] restore_mark;

    arch_addr_t rec_arch;
    phys_addr_t rec_spec;
    phys_addr_t rec_prev;
    logic       retire_fire;

    // Unpack the oldest record
    assign rec_arch = head_rec[`ARCH_W+2*`PHYS_W-1 -: `ARCH_W];
    assign rec_spec = head_rec[2*`PHYS_W-1 -: `PHYS_W];
    assign rec_prev = head_rec[`PHYS_W-1:0];

    // Retire waits only on a record being present
    assign retire_ready = head_valid;
    assign head_ready   = retire_valid;
    assign retire_fire  = retire_valid & head_valid;

    // Commit frees the old mapping, discard frees the speculative one
    assign free_push      = retire_fire;
    assign free_push_phys = retire_discard ? rec_spec : rec_prev;

    // Only the first discard per register since flush rolls the map back
    // since later discards are younger and would restore a stale value
    assign restore_valid = retire_fire & retire_discard & ~restore_mark[rec_arch];
    assign restore_arch  = rec_arch;
    assign restore_phys  = rec_prev;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            restore_mark <= '0;
        end else if (flush) begin
            restore_mark <= '0;
        end else if (restore_valid) begin
            restore_mark[rec_arch] <= 1'b1;
        end
    end

endmodule

//--- reg_renamer.sv
/*
 * Register renamer top
 * Free list, map table, in-use list and retire reclaim
 */
module reg_renamer
    import reg_rename_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    // Rename path
    input  logic       rename_valid,
    input  arch_addr_t rd,
    input  arch_addr_t rs1,
    input  arch_addr_t rs2,
    output logic       rename_ready,
    output phys_addr_t phys_rd,
    output phys_addr_t phys_rs1,
    output phys_addr_t phys_rs2,
    // Retire path
    input  logic       retire_valid,
    input  logic       retire_discard,
    output logic       retire_ready,
    input  logic       flush
);
    // Free list traffic
    logic       free_pop;
    logic       free_push;
    phys_addr_t free_push_phys;
    phys_addr_t free_head;
    logic       free_avail;

    // Post-reset fill
    logic       init_active;
    arch_addr_t init_index;

    // In-use records
    logic       rec_push;
    inuse_rec_t rec_in;
    logic       inuse_full;
    logic       head_valid;
    inuse_rec_t head_rec;
    logic       head_ready;

    // Map rollback on discard
    logic       restore_valid;
    arch_addr_t restore_arch;
    phys_addr_t restore_phys;

    //////////////////////////////
    // Producer side
    //////////////////////////////
    free_list u_free_list (
        .clk            (clk),
        .arst_n         (arst_n),
        .free_pop       (free_pop),
        .free_push      (free_push),
        .free_push_phys (free_push_phys),
        .free_head      (free_head),
        .free_avail     (free_avail),
        .init_active    (init_active),
        .init_index     (init_index)
    );

    spec_map_table u_spec_map_table (
        .clk           (clk),
        .arst_n        (arst_n),
        .init_active   (init_active),
        .init_index    (init_index),
        .rename_valid  (rename_valid),
        .rd            (rd),
        .rs1           (rs1),
        .rs2           (rs2),
        .rename_ready  (rename_ready),
        .phys_rd       (phys_rd),
        .phys_rs1      (phys_rs1),
        .phys_rs2      (phys_rs2),
        .free_head     (free_head),
        .free_avail    (free_avail),
        .free_pop      (free_pop),
        .inuse_full    (inuse_full),
        .rec_push      (rec_push),
        .rec_in        (rec_in),
        .restore_valid (restore_valid),
        .restore_arch  (restore_arch),
        .restore_phys  (restore_phys)
    );

    //////////////////////////////
    // Buffer and consumer
    //////////////////////////////
    inuse_list u_inuse_list (
        .clk        (clk),
        .arst_n     (arst_n),
        .rec_push   (rec_push),
        .rec_in     (rec_in),
        .inuse_full (inuse_full),
        .head_valid (head_valid),
        .head_rec   (head_rec),
        .head_ready (head_ready)
    );

    retire_reclaim u_retire_reclaim (
        .clk            (clk),
        .arst_n         (arst_n),
        .retire_valid   (retire_valid),
        .retire_discard (retire_discard),
        .flush          (flush),
        .retire_ready   (retire_ready),
        .head_valid     (head_valid),
        .head_rec       (head_rec),
        .head_ready     (head_ready),
        .free_push      (free_push),
        .free_push_phys (free_push_phys),
        .restore_valid  (restore_valid),
        .restore_arch   (restore_arch),
        .restore_phys   (restore_phys)
    );

endmodule

//--- reg_renamer_properties.sv
/*
 * Register renamer properties
 * Zero-register and init handshake rules, bound to the top level
 */
module reg_renamer_properties
    import reg_rename_pkg::*;
(
    input logic       clk,
    input logic       arst_n,
    input logic       rename_ready,
    input logic       retire_ready,
    input logic       init_active,
    input arch_addr_t rd,
    input arch_addr_t rs1,
    input arch_addr_t rs2,
    input phys_addr_t phys_rd,
    input phys_addr_t phys_rs1,
    input phys_addr_t phys_rs2
);
    timeunit 1ns;
    timeprecision 1ps;

    // Register zero never gets a physical destination
    zero_rd_a: assert property (@(posedge clk) disable iff (!arst_n)
        (rd == '0) |-> (phys_rd == '0))
        else $error("phys_rd is nonzero for rd zero");

    // Register zero sources read physical zero
    zero_rs1_a: assert property (@(posedge clk) disable iff (!arst_n)
        (rs1 == '0) |-> (phys_rs1 == '0))
        else $error("phys_rs1 is nonzero for rs1 zero");

    zero_rs2_a: assert property (@(posedge clk) disable iff (!arst_n)
        (rs2 == '0) |-> (phys_rs2 == '0))
        else $error("phys_rs2 is nonzero for rs2 zero");

    // No handshake while the tables fill
    init_retire_a: assert property (@(posedge clk) disable iff (!arst_n)
        init_active |-> !retire_ready)
        else $error("retire_ready high during table fill");

    init_rename_a: assert property (@(posedge clk) disable iff (!arst_n)
        init_active |-> !rename_ready)
        else $error("rename_ready high during table fill");

endmodule

bind reg_renamer reg_renamer_properties u_reg_renamer_properties (
    .clk          (clk),
    .arst_n       (arst_n),
    .rename_ready (rename_ready),
    .retire_ready (retire_ready),
    .init_active  (init_active),
    .rd           (rd),
    .rs1          (rs1),
    .rs2          (rs2),
    .phys_rd      (phys_rd),
    .phys_rs1     (phys_rs1),
    .phys_rs2     (phys_rs2)
);

//--- tb_reg_renamer.sv
/*
 * Register renamer testbench
 * Runs the operation list from the tests file against a reference model
 */
`include "reg_rename_defs.svh"

module tb_reg_renamer
    import reg_rename_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 8;
    localparam int DRIVE_DLY     = 1;
    localparam int READY_TIMEOUT = 100;
    localparam int STALL_TIMEOUT = 40;
    localparam int TEST_MAX      = 64;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       rename_valid;
    arch_addr_t rd;
    arch_addr_t rs1;
    arch_addr_t rs2;
    logic       rename_ready;
    phys_addr_t phys_rd;
    phys_addr_t phys_rs1;
    phys_addr_t phys_rs2;
    logic       retire_valid;
    logic       retire_discard;
    logic       retire_ready;
    logic       flush;

    // Op list with one 40-bit word per line holding op, rd, rs1, rs2 and expected phys_rd
    logic [39:0] test_mem [TEST_MAX];

    // Reference model state
    phys_addr_t            model_map [`ARCH_REGS];
    phys_addr_t            free_q [$];
    inuse_rec_t            rec_q [$];
    logic [`ARCH_REGS-1:0] model_mark;

    int value_errors = 0;
    int other_errors = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    reg_renamer u_reg_renamer (
        .clk            (clk),
        .arst_n         (arst_n),
        .rename_valid   (rename_valid),
        .rd             (rd),
        .rs1            (rs1),
        .rs2            (rs2),
        .rename_ready   (rename_ready),
        .phys_rd        (phys_rd),
        .phys_rs1       (phys_rs1),
        .phys_rs2       (phys_rs2),
        .retire_valid   (retire_valid),
        .retire_discard (retire_discard),
        .retire_ready   (retire_ready),
        .flush          (flush)
    );

    //////////////////////////////
    // Checks and waits
    //////////////////////////////
    task automatic check_value(input string name, input phys_addr_t got, input phys_addr_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            value_errors++;
        end
    endtask

    // Sampled at the falling edge between drive points
    task automatic wait_rename_ready(output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            if (rename_ready) ok = 1'b1;
            else cycles++;
        end
        if (!ok) begin
            $display("Timed out waiting for rename_ready to rise");
            other_errors++;
        end
    endtask

    task automatic wait_retire_ready(output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            if (retire_ready) ok = 1'b1;
            else cycles++;
        end
        if (!ok) begin
            $display("Timed out waiting for retire_ready to rise");
            other_errors++;
        end
    endtask

    //////////////////////////////
    // Operations
    //////////////////////////////
    task automatic rename_instr(input arch_addr_t a_rd, input arch_addr_t a_rs1,
                                input arch_addr_t a_rs2, input phys_addr_t a_exp,
                                input bit use_exp);
        phys_addr_t want_rd;
        bit         ok;
        rename_valid = 1'b1;
        rd  = a_rd;
        rs1 = a_rs1;
        rs2 = a_rs2;
        wait_rename_ready(ok);
        if (ok) begin
            // Zero rd gets physical zero and leaves the free list alone
            want_rd = (a_rd == '0) ? '0 : free_q[0];
            if (use_exp && want_rd !== a_exp) begin
                $display("Tests file and reference model disagree on phys_rd for rd %0d", a_rd);
                other_errors++;
            end
            check_value("phys_rs1", phys_rs1, model_map[a_rs1]);
            check_value("phys_rs2", phys_rs2, model_map[a_rs2]);
            check_value("phys_rd", phys_rd, want_rd);
        end
        @(posedge clk);
        #DRIVE_DLY;
        rename_valid = 1'b0;
        if (ok && a_rd != '0) begin
            void'(free_q.pop_front());
            rec_q.push_back({a_rd, want_rd, model_map[a_rd]});
            model_map[a_rd] = want_rd;
        end
    endtask

    task automatic retire_oldest(input bit discard);
        inuse_rec_t rec;
        bit         ok;
        retire_valid   = 1'b1;
        retire_discard = discard;
        wait_retire_ready(ok);
        @(posedge clk);
        #DRIVE_DLY;
        retire_valid   = 1'b0;
        retire_discard = 1'b0;
        if (ok && rec_q.size() != 0) begin
            // Record holds arch, speculative, previous from the top
            rec = rec_q.pop_front();
            if (discard) begin
                free_q.push_back(rec[11:6]);
                if (!model_mark[rec[16:12]]) begin
                    model_map[rec[16:12]]  = rec[5:0];
                    model_mark[rec[16:12]] = 1'b1;
                end
            end else begin
                free_q.push_back(rec[5:0]);
            end
        end
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        flush      = 1'b0;
        model_mark = '0;
    endtask

    // Hold a rename while both lists are full and expect ready to stay low
    task automatic expect_stall(input arch_addr_t a_rd);
        int cycles;
        bit accepted;
        cycles   = 0;
        accepted = 1'b0;
        if (free_q.size() != 0) begin
            $display("Stall step reached with free registers left in the model");
            other_errors++;
        end
        rename_valid = 1'b1;
        rd  = a_rd;
        rs1 = '0;
        rs2 = '0;
        while (!accepted && cycles < STALL_TIMEOUT) begin
            @(negedge clk);
            if (rename_ready) accepted = 1'b1;
            else cycles++;
        end
        if (accepted) begin
            $display("rename_ready rose with no free register and no retire");
            other_errors++;
        end
        @(posedge clk);
        #DRIVE_DLY;
        rename_valid = 1'b0;
    endtask

    // Compare every source lookup and both ready flags with the model
    task automatic sweep_sources();
        for (int a = 0; a < `ARCH_REGS; a++) begin
            rs1 = arch_addr_t'(a);
            rs2 = arch_addr_t'(`ARCH_REGS - 1 - a);
            @(negedge clk);
            check_value("phys_rs1", phys_rs1, model_map[a]);
            check_value("phys_rs2", phys_rs2, model_map[`ARCH_REGS - 1 - a]);
            @(posedge clk);
            #DRIVE_DLY;
        end
        // Ready needs a free register and room for a record
        @(negedge clk);
        check_flag("rename_ready", rename_ready,
                   free_q.size() != 0 && rec_q.size() < `INUSE_DEPTH);
        check_flag("retire_ready", retire_ready, rec_q.size() != 0);
        @(posedge clk);
        #DRIVE_DLY;
        rs1 = '0;
        rs2 = '0;
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        logic [39:0] entry;
        bit          ok;
        arst_n         = 1'b0;
        rename_valid   = 1'b0;
        rd             = '0;
        rs1            = '0;
        rs2            = '0;
        retire_valid   = 1'b0;
        retire_discard = 1'b0;
        flush          = 1'b0;
        model_mark     = '0;
        // Identity map with the upper registers free in order
        for (int i = 0; i < `ARCH_REGS; i++) begin
            model_map[i] = phys_addr_t'(i);
            free_q.push_back(phys_addr_t'(`ARCH_REGS + i));
        end
        for (int i = 0; i < TEST_MAX; i++) test_mem[i] = '0;
        $readmemh("reg_rename_tests.txt", test_mem);

        repeat (4) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;
        // Table fill runs first
        wait_rename_ready(ok);
        @(posedge clk);
        #DRIVE_DLY;

        for (int i = 0; i < TEST_MAX; i++) begin
            entry = test_mem[i];
            if (entry[39:32] == 8'h00) break;
            case (entry[39:32])
                8'h01: rename_instr(entry[28:24], entry[20:16], entry[12:8], entry[5:0], 1'b1);
                8'h02: retire_oldest(1'b0);
                8'h03: retire_oldest(1'b1);
                8'h04: pulse_flush();
                8'h05: expect_stall(entry[28:24]);
                8'h06: begin
                    // Drain the free list with expected values from the model
                    for (int k = 0; k < `FREE_DEPTH && free_q.size() != 0; k++) begin
                        rename_instr(entry[28:24], '0, entry[28:24], '0, 1'b0);
                    end
                end
                8'h07: sweep_sources();
                default: begin
                    $display("Unknown operation code 0x%0h on tests entry %0d", entry[39:32], i);
                    other_errors++;
                end
            endcase
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- reg_rename_tests.txt
// Columns: op_rd_rs1_rs2_exp in hex bytes, exp is the expected phys_rd of a rename
// op 01 rename, 02 commit, 03 discard, 04 flush, 05 expect stall, 06 fill, 07 source sweep
07_00_00_00_00
01_05_01_02_20
01_06_05_00_21
01_00_06_05_00
01_07_06_07_22
02_00_00_00_00
01_05_05_00_23
02_00_00_00_00
02_00_00_00_00
01_09_09_00_24
01_09_09_00_25
02_00_00_00_00
03_00_00_00_00
03_00_00_00_00
01_00_09_09_00
04_00_00_00_00
01_09_00_00_26
01_09_09_00_27
03_00_00_00_00
01_00_09_00_00
03_00_00_00_00
01_00_09_00_00
06_03_00_00_00
05_04_00_00_00
02_00_00_00_00
01_04_03_04_03
07_00_00_00_00

//--- compile.f
+incdir+.
reg_rename_pkg.sv
free_list.sv
spec_map_table.sv
inuse_list.sv
retire_reclaim.sv
reg_renamer.sv
reg_renamer_properties.sv
tb_reg_renamer.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_reg_renamer
FILELIST = compile.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
